// File: u2_rx_core.f
+incdir+.
u2_rx_pkg.sv
rx_stream_if.sv
vita_timer.sv
rx_frame_fifo.sv
rx_frame_chain.sv
rx_stream_merge.sv
u2_rx_core.sv
tb_u2_rx_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the u2_rx_core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_u2_rx_core \
   -f u2_rx_core.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_u2_rx_core > sim.log 2>&1
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "Simulation failed"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

// File: tb_u2_rx_core.sv
// Directed testbench for the dual receive core
// Drives settings and ADC inputs, checks time, status and the merged frames
`timescale 1ns/10ps
`include "u2_rx_config.svh"

module tb_u2_rx_core;
   import u2_rx_pkg::*;

   localparam int CLK_PERIOD = 4;
   localparam int ADC_W      = `U2_RX_ADC_W;
   localparam int FIFO_DEPTH = 1 << `U2_RX_FIFO_AW;
   localparam int IDLE_CYC   = 100;
   localparam int WORD_WAIT  = 64;
   localparam int OVR_WAIT   = 400;
   // Upper bound of words per test (frames times frame size), about 8 cycles each
   localparam int EXP_WORDS    = 6 * 5 + 7 * 12 + 5 * 8 + 8 * 4 + 5 * 4;
   localparam int WATCHDOG_CYC = EXP_WORDS * 8 + 8 * IDLE_CYC + OVR_WAIT;
   localparam set_addr_t TIME_HI = set_addr_t'(`U2_SR_TIME64);
   localparam set_addr_t TIME_LO = set_addr_t'(`U2_SR_TIME64 + 1);

   logic              dsp_clk;
   logic              rst_n_i;
   logic              set_stb_i;
   set_addr_t         set_addr_i;
   set_data_t         set_data_i;
   logic [ADC_W-1:0]  adc_a_i;
   logic [ADC_W-1:0]  adc_b_i;
   logic [31:0]       rx_data_o;
   logic              rx_sop_o;
   logic              rx_eop_o;
   chan_id_t          rx_chan_o;
   logic              rx_valid_o;
   logic              rx_ready_i;
   logic [1:0]        running_o;
   logic [1:0]        overrun_o;
   vita_time_t        vita_time_o;

   // Last word taken from the output, and per-channel expectations
   sample_t           w_data;
   logic              w_sop;
   logic              w_eop;
   chan_id_t          w_chan;
   chan_id_t          f_chan;
   int                exp_len [2];
   int                exp_dec [2];
   int                frame_cnt [2];
   bit                have_last [2];
   logic [ADC_W-1:0]  last_a [2];

   u2_rx_core u2_rx_core_inst (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .rx_data_o   (rx_data_o),
      .rx_sop_o    (rx_sop_o),
      .rx_eop_o    (rx_eop_o),
      .rx_chan_o   (rx_chan_o),
      .rx_valid_o  (rx_valid_o),
      .rx_ready_i  (rx_ready_i),
      .running_o   (running_o),
      .overrun_o   (overrun_o),
      .vita_time_o (vita_time_o)
   );

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_time(input vita_time_t got, input vita_time_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s, got %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_word(input sample_t got, input sample_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s, got %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_chan(input chan_id_t got, input chan_id_t exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("Error at %0t: %s, got %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         fail_run($sformatf("Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   function automatic logic [15:0] sign_extend(input logic [ADC_W-1:0] v);
      return {{(16 - ADC_W){v[ADC_W-1]}}, v};
   endfunction

   function automatic set_addr_t chan_base(input chan_id_t ch);
      return ch ? set_addr_t'(`U2_SR_RX_CTRL1) : set_addr_t'(`U2_SR_RX_CTRL0);
   endfunction

   //////////////////////////////
   // Settings bus
   //////////////////////////////

   // Called on a falling edge, returns on the next one
   task automatic set_write(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i  = 1'b0;
   endtask

   task automatic send_cmd(input chan_id_t ch, input bit go);
      set_write(chan_base(ch) + 8'd2, set_data_t'(go));
      if (go) begin
         have_last[ch] = 1'b0;
         check_flag(running_o[ch], 1'b1, "running after start");
         check_flag(overrun_o[ch], 1'b0, "overrun after start");
      end
   endtask

   task automatic start_chan(input chan_id_t ch, input int len, input int dec);
      set_write(chan_base(ch), set_data_t'(len));
      set_write(chan_base(ch) + 8'd1, set_data_t'(dec));
      exp_len[ch] = len;
      exp_dec[ch] = dec;
      send_cmd(ch, 1'b1);
   endtask

   //////////////////////////////
   // Output stream
   //////////////////////////////

   // A word seen with valid and ready on a falling edge moves on the next rising edge
   task automatic get_word(input int wait_cyc, output bit got);
      int n;
      n   = 0;
      got = 1'b0;
      while (!got && n < wait_cyc) begin
         if (rx_valid_o && rx_ready_i) begin
            w_data = rx_data_o;
            w_sop  = rx_sop_o;
            w_eop  = rx_eop_o;
            w_chan = rx_chan_o;
            got    = 1'b1;
         end
         @(negedge dsp_clk);
         n++;
      end
   endtask

   task automatic collect_frame(input int wait_cyc, output bit got);
      logic [ADC_W-1:0] exp_a;
      logic [ADC_W-1:0] step;
      int               n;
      bit               ok;
      get_word(wait_cyc, got);
      if (!got) begin
         return;
      end
      check_flag(w_sop, 1'b1, "header sop");
      check_flag(w_eop, 1'b0, "header eop");
      f_chan = w_chan;
      step   = ADC_W'(exp_dec[f_chan]);
      // Header time matches the first adc_a sample
      exp_a  = w_data[ADC_W-1:0];
      if (have_last[f_chan]) begin
         check_word(sample_t'(exp_a), sample_t'(ADC_W'(last_a[f_chan] + step)),
                    "step across frames");
      end
      n = 0;
      while (!w_eop) begin
         get_word(WORD_WAIT, ok);
         if (!ok) begin
            fail_run("Frame stopped before its eop word arrived");
         end
         check_chan(w_chan, f_chan, "channel within a frame");
         check_flag(w_sop, 1'b0, "sample sop");
         check_word(w_data, {sign_extend(exp_a), sign_extend(adc_b_i)}, "sample fields");
         exp_a = exp_a + step;
         n++;
         if (n > `U2_RX_MAX_SPF && !w_eop) begin
            fail_run("Frame runs past the largest frame length");
         end
      end
      check_count(n, exp_len[f_chan], "samples per frame");
      last_a[f_chan]    = exp_a - step;
      have_last[f_chan] = 1'b1;
      frame_cnt[f_chan]++;
   endtask

   // Takes whole frames until the output stays idle
   task automatic drain_frames(output int count);
      bit got;
      count      = 0;
      got        = 1'b1;
      rx_ready_i = 1'b1;
      while (got) begin
         collect_frame(IDLE_CYC, got);
         if (got) begin
            count++;
         end
      end
      rx_ready_i = 1'b0;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_reset_and_time();
      vita_time_t t;
      int         i;
      check_flag(rx_valid_o, 1'b0, "valid after reset");
      check_count(running_o, 0, "running after reset");
      check_count(overrun_o, 0, "overrun after reset");
      set_write(TIME_HI, 32'h0000_0012);
      set_write(TIME_LO, 32'hffff_fffc);
      t = 64'h0000_0012_ffff_fffc;
      // Runs across the carry into the high word
      for (i = 0; i < 6; i++) begin
         check_time(vita_time_o, t, "time count");
         t = t + 1;
         @(negedge dsp_clk);
      end
   endtask

   task automatic test_single_channel();
      bit got;
      int i;
      int n;
      adc_b_i = ADC_W'($urandom);
      start_chan(1'b0, 5, 3);
      rx_ready_i = 1'b1;
      for (i = 0; i < 3; i++) begin
         collect_frame(IDLE_CYC, got);
         if (!got) begin
            fail_run("No frame from channel 0");
         end
         check_chan(f_chan, 1'b0, "frame channel");
      end
      rx_ready_i = 1'b0;
      send_cmd(1'b0, 1'b0);
      drain_frames(n);
      check_flag(running_o[0], 1'b0, "channel 0 running after stop");
   endtask

   task automatic test_dual_channel();
      bit got;
      int i;
      int n;
      adc_b_i      = ADC_W'($urandom);
      frame_cnt[0] = 0;
      frame_cnt[1] = 0;
      start_chan(1'b0, 4, 4);
      start_chan(1'b1, 6, 3);
      rx_ready_i = 1'b1;
      for (i = 0; i < 8; i++) begin
         collect_frame(IDLE_CYC, got);
         if (!got) begin
            fail_run("Merged stream went quiet with both channels running");
         end
      end
      rx_ready_i = 1'b0;
      send_cmd(1'b0, 1'b0);
      send_cmd(1'b1, 1'b0);
      drain_frames(n);
      if (frame_cnt[0] == 0 || frame_cnt[1] == 0) begin
         fail_run("One channel sent no frames while both were running");
      end
      check_count(running_o, 0, "running after stopping both");
   endtask

   task automatic test_overrun();
      int n;
      adc_b_i = ADC_W'($urandom);
      start_chan(1'b0, 4, 2);
      n = 0;
      while (!overrun_o[0] && n < OVR_WAIT) begin
         @(negedge dsp_clk);
         n++;
      end
      if (!overrun_o[0]) begin
         fail_run("Channel 0 never reported an overrun with the output held");
      end
      check_flag(running_o[0], 1'b0, "running after overrun");
      drain_frames(n);
      // The FIFO plus the one word held at the merger output
      check_count(n, (FIFO_DEPTH + 1) / 5, "frames kept through the overrun");
      send_cmd(1'b0, 1'b1);
      send_cmd(1'b0, 1'b0);
      drain_frames(n);
      check_flag(running_o[0], 1'b0, "running after stop");
   endtask

   task automatic test_stop();
      bit got;
      int i;
      int n;
      adc_b_i = ADC_W'($urandom);
      start_chan(1'b1, 7, 2);
      rx_ready_i = 1'b1;
      for (i = 0; i < 2; i++) begin
         collect_frame(IDLE_CYC, got);
         if (!got) begin
            fail_run("No frame from channel 1");
         end
      end
      rx_ready_i = 1'b0;
      // Let the next frame get under way
      repeat (5) @(negedge dsp_clk);
      send_cmd(1'b1, 1'b0);
      drain_frames(n);
      // Only the frame under way at the stop
      check_count(n, 1, "frames finished after stop");
      check_flag(running_o[1], 1'b0, "channel 1 running after stop");
      repeat (IDLE_CYC) begin
         @(negedge dsp_clk);
         if (rx_valid_o) begin
            fail_run("A frame arrived after the stop had finished");
         end
      end
   endtask

   task automatic test_stray_writes();
      vita_time_t t;
      bit         got;
      int         i;
      int         n;
      adc_b_i = ADC_W'($urandom);
      t = vita_time_o;
      set_write(8'd35, 32'h0000_0003);
      set_write(8'd175, 32'h0000_0003);
      set_write(8'd179, 32'h0000_0003);
      set_write(8'd191, 32'h0000_0003);
      set_write(8'd194, 32'h0000_0003);
      check_time(vita_time_o, t + 5, "time after stray writes");
      check_count(running_o, 0, "running after stray writes");
      // Channel 0 keeps length 4 and decimation 2
      send_cmd(1'b0, 1'b1);
      rx_ready_i = 1'b1;
      for (i = 0; i < 2; i++) begin
         collect_frame(IDLE_CYC, got);
         if (!got) begin
            fail_run("No frame from channel 0 after stray writes");
         end
         check_chan(f_chan, 1'b0, "frame channel");
      end
      rx_ready_i = 1'b0;
      send_cmd(1'b0, 1'b0);
      drain_frames(n);
   endtask

   //////////////////////////////
   // Clock, ADC drive, watchdog
   //////////////////////////////

   initial begin
      dsp_clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
      end
   end

   // adc_a follows the time counter
   initial begin
      forever begin
         @(negedge dsp_clk);
         adc_a_i = vita_time_o[ADC_W-1:0];
      end
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
   end

   initial begin
      void'($urandom(32'h1f98_4176));
      rst_n_i    = 1'b0;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      adc_a_i    = '0;
      adc_b_i    = '0;
      rx_ready_i = 1'b0;
      for (int c = 0; c < 2; c++) begin
         exp_len[c]   = 1;
         exp_dec[c]   = 1;
         frame_cnt[c] = 0;
         have_last[c] = 1'b0;
         last_a[c]    = '0;
      end
      repeat (3) @(negedge dsp_clk);
      check_time(vita_time_o, '0, "time in reset");
      rst_n_i = 1'b1;
      test_reset_and_time();
      test_single_channel();
      test_dual_channel();
      test_overrun();
      test_stop();
      test_stray_writes();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: u2_rx_core.sv
// Dual receive core: time counter, two framing channels and the stream merger
// Everything runs on dsp_clk
`timescale 1ns/10ps
`include "u2_rx_config.svh"

module u2_rx_core (
   input  logic                    dsp_clk,
   input  logic                    rst_n_i,
   input  logic                    set_stb_i,
   input  logic [7:0]              set_addr_i,
   input  logic [31:0]             set_data_i,
   input  logic [`U2_RX_ADC_W-1:0] adc_a_i,
   input  logic [`U2_RX_ADC_W-1:0] adc_b_i,
   output logic [31:0]             rx_data_o,
   output logic                    rx_sop_o,
   output logic                    rx_eop_o,
   output logic                    rx_chan_o,
   output logic                    rx_valid_o,
   input  logic                    rx_ready_i,
   output logic [1:0]              running_o,
   output logic [1:0]              overrun_o,
   output logic [63:0]             vita_time_o
);

   rx_stream_if rx0_stream ();
   rx_stream_if rx1_stream ();

   //////////////////////////////
   // Time base
   //////////////////////////////

   vita_timer vita_timer_inst (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_o (vita_time_o)
   );

   //////////////////////////////
   // Receive channels
   //////////////////////////////

   rx_frame_chain #(
      .BASE (`U2_SR_RX_CTRL0)
   ) rx_frame_chain0 (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_i (vita_time_o),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .out         (rx0_stream),
      .running_o   (running_o[0]),
      .overrun_o   (overrun_o[0])
   );

   rx_frame_chain #(
      .BASE (`U2_SR_RX_CTRL1)
   ) rx_frame_chain1 (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_i (vita_time_o),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .out         (rx1_stream),
      .running_o   (running_o[1]),
      .overrun_o   (overrun_o[1])
   );

   // Single output stream
   rx_stream_merge rx_stream_merge_inst (
      .dsp_clk (dsp_clk),
      .rst_n_i (rst_n_i),
      .in0     (rx0_stream),
      .in1     (rx1_stream),
      .data_o  (rx_data_o),
      .sop_o   (rx_sop_o),
      .eop_o   (rx_eop_o),
      .chan_o  (rx_chan_o),
      .valid_o (rx_valid_o),
      .ready_i (rx_ready_i)
   );

endmodule

// File: rx_stream_merge.sv
// Merges the two channel streams frame by frame
// Tags each word with its channel, alternates when both have a frame waiting
`timescale 1ns/10ps

module rx_stream_merge (
   input  logic                dsp_clk,
   input  logic                rst_n_i,
   rx_stream_if.snk            in0,
   rx_stream_if.snk            in1,
   output logic [31:0]         data_o,
   output logic                sop_o,
   output logic                eop_o,
   output u2_rx_pkg::chan_id_t chan_o,
   output logic                valid_o,
   input  logic                ready_i
);
   import u2_rx_pkg::*;

   frame_word_t out_word;
   frame_word_t cur_word;
   chan_id_t    out_chan;
   chan_id_t    sel;
   chan_id_t    last_sel;
   chan_id_t    pick;
   chan_id_t    cur;
   logic        out_valid;
   logic        locked;
   logic        cur_valid;
   logic        load_ok;
   logic        take;

   // Both waiting: the channel that did not go last wins
   assign pick      = (in0.valid && in1.valid) ? !last_sel : in1.valid;
   assign cur       = locked ? sel : pick;
   assign cur_valid = cur ? in1.valid : in0.valid;
   assign cur_word  = cur ? in1.word : in0.word;
   assign load_ok   = !out_valid || ready_i;
   assign take      = load_ok && cur_valid;

   assign in0.ready = take && (cur == 1'b0);
   assign in1.ready = take && (cur == 1'b1);

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         out_valid <= 1'b0;
         locked    <= 1'b0;
         sel       <= 1'b0;
         last_sel  <= 1'b1;
      end else if (take) begin
         out_valid <= 1'b1;
         if (cur_word.eop) begin
            locked   <= 1'b0;
            last_sel <= cur;
         end else if (cur_word.sop) begin
            locked <= 1'b1;
            sel    <= cur;
         end
      end else if (ready_i) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (take) begin
         out_word <= cur_word;
         out_chan <= cur;
      end
   end

   assign data_o  = out_word.data;
   assign sop_o   = out_word.sop;
   assign eop_o   = out_word.eop;
   assign chan_o  = out_chan;
   assign valid_o = out_valid;

   a_hold_output : assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      (valid_o && !ready_i) |=> (valid_o && $stable(data_o) && $stable(sop_o)
                                 && $stable(eop_o) && $stable(chan_o)));

endmodule

// File: rx_frame_chain.sv
// One receive channel: settings registers, sample strobe and framer
// Frames are a time-stamp header followed by L samples, buffered in a FIFO
`timescale 1ns/10ps
`include "u2_rx_config.svh"

module rx_frame_chain #(
   parameter int BASE = 0
) (
   input  logic                    dsp_clk,
   input  logic                    rst_n_i,
   input  logic                    set_stb_i,
   input  u2_rx_pkg::set_addr_t    set_addr_i,
   input  u2_rx_pkg::set_data_t    set_data_i,
   input  u2_rx_pkg::vita_time_t   vita_time_i,
   input  logic [`U2_RX_ADC_W-1:0] adc_a_i,
   input  logic [`U2_RX_ADC_W-1:0] adc_b_i,
   rx_stream_if.src                out,
   output logic                    running_o,
   output logic                    overrun_o
);
   import u2_rx_pkg::*;

   localparam int SPF_W = $clog2(`U2_RX_MAX_SPF + 1);
   localparam int DEC_W = 16;
   localparam int EXT_W = 16 - `U2_RX_ADC_W;
   localparam set_addr_t ADDR_SPF = set_addr_t'(BASE);
   localparam set_addr_t ADDR_DEC = set_addr_t'(BASE + 1);
   localparam set_addr_t ADDR_CMD = set_addr_t'(BASE + 2);

   logic [SPF_W-1:0]        spf_r;
   logic [DEC_W-1:0]        dec_r;
   logic [DEC_W-1:0]        dec_cnt;
   logic [SPF_W-1:0]        idx;
   logic [SPF_W:0]          need;
   logic [`U2_RX_FIFO_AW:0] free;
   logic                    run_r;
   logic                    stop_pend;
   logic                    overrun_r;
   logic                    strobe;
   logic                    at_boundary;
   logic                    room_ok;
   logic                    start_slot;
   logic                    frame_go;
   logic                    take;
   logic                    last;
   logic                    wr_cmd;
   logic                    hold_valid;
   frame_word_t             hold_word;
   frame_word_t             hdr_word;
   sample_t                 sample_now;

   rx_stream_if fifo_in ();

   //////////////////////////////
   // Sample strobe and framing
   //////////////////////////////

   assign strobe      = run_r && (dec_cnt == '0);
   assign at_boundary = (idx == '0);
   assign need        = {1'b0, spf_r} + (SPF_W + 1)'(1);
   assign room_ok     = (free >= need);
   // With decimation 1 the last sample of a frame is still held, so the slot is skipped
   assign start_slot  = strobe && at_boundary && !stop_pend && !hold_valid;
   assign frame_go    = start_slot && room_ok;
   assign take        = frame_go || (strobe && !at_boundary);
   assign last        = (idx == spf_r - 1'b1);
   assign wr_cmd      = set_stb_i && (set_addr_i == ADDR_CMD);

   assign sample_now = {{EXT_W{adc_a_i[`U2_RX_ADC_W-1]}}, adc_a_i,
                        {EXT_W{adc_b_i[`U2_RX_ADC_W-1]}}, adc_b_i};
   assign hdr_word   = '{eop: 1'b0, sop: 1'b1, data: vita_time_i[31:0]};

   // Header goes straight in, samples pass through the hold register
   assign fifo_in.valid = frame_go || hold_valid;
   assign fifo_in.word  = frame_go ? hdr_word : hold_word;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         spf_r      <= '0;
         dec_r      <= '0;
         dec_cnt    <= '0;
         idx        <= '0;
         run_r      <= 1'b0;
         stop_pend  <= 1'b0;
         overrun_r  <= 1'b0;
         hold_valid <= 1'b0;
      end else begin
         // Zero frame length is ignored, longer ones are clipped
         if (set_stb_i && set_addr_i == ADDR_SPF && set_data_i != '0) begin
            spf_r <= (set_data_i > `U2_RX_MAX_SPF) ? SPF_W'(`U2_RX_MAX_SPF)
                                                   : set_data_i[SPF_W-1:0];
         end
         if (set_stb_i && set_addr_i == ADDR_DEC) begin
            dec_r <= set_data_i[DEC_W-1:0];
         end

         // Decimation 0 behaves as 1
         if (strobe) begin
            dec_cnt <= (dec_r == '0) ? '0 : dec_r - 1'b1;
         end else if (dec_cnt != '0) begin
            dec_cnt <= dec_cnt - 1'b1;
         end

         if (take) begin
            idx        <= last ? '0 : idx + 1'b1;
            hold_valid <= 1'b1;
         end else if (hold_valid && fifo_in.ready) begin
            hold_valid <= 1'b0;
         end

         // No room for a whole frame
         if (start_slot && !room_ok) begin
            run_r     <= 1'b0;
            overrun_r <= 1'b1;
         end else if (stop_pend && at_boundary) begin
            run_r     <= 1'b0;
            stop_pend <= 1'b0;
         end

         // Command register, bit 0 is start
         if (wr_cmd) begin
            if (set_data_i[0]) begin
               overrun_r <= 1'b0;
               stop_pend <= 1'b0;
               if (!run_r && spf_r != '0) begin
                  run_r   <= 1'b1;
                  dec_cnt <= '0;
               end
            end else if (run_r) begin
               stop_pend <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (take) begin
         hold_word <= '{eop: last, sop: 1'b0, data: sample_now};
      end
   end

   rx_frame_fifo #(
      .ADDR_W (`U2_RX_FIFO_AW)
   ) rx_frame_fifo_inst (
      .dsp_clk (dsp_clk),
      .rst_n_i (rst_n_i),
      .wr      (fifo_in),
      .rd      (out),
      .free_o  (free)
   );

   assign running_o = run_r;
   assign overrun_o = overrun_r;

   // Start is refused without a frame length, and zero writes are dropped
   a_spf_nonzero : assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i) run_r |-> (spf_r != '0));

endmodule

// File: rx_frame_fifo.sv
// Synchronous FIFO of frame words for one receive channel
// Reports its free space so whole frames can be reserved
`timescale 1ns/10ps

module rx_frame_fifo #(
   parameter int ADDR_W = 5
) (
   input  logic            dsp_clk,
   input  logic            rst_n_i,
   rx_stream_if.snk        wr,
   rx_stream_if.src        rd,
   output logic [ADDR_W:0] free_o
);
   import u2_rx_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   frame_word_t     mem [DEPTH];
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;
   logic [ADDR_W:0] used;
   logic            full;
   logic            push;
   logic            pop;

   // Pointers carry one extra wrap bit
   assign used   = wr_ptr - rd_ptr;
   assign full   = used[ADDR_W];
   assign free_o = (ADDR_W + 1)'(DEPTH) - used;

   assign wr.ready = !full;
   assign push     = wr.valid && !full;
   assign rd.valid = (used != '0);
   assign rd.word  = mem[rd_ptr[ADDR_W-1:0]];
   assign pop      = rd.valid && rd.ready;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (push) begin
         mem[wr_ptr[ADDR_W-1:0]] <= wr.word;
      end
   end

   // The writer reserves room per frame, so it never offers a word to a full FIFO
   a_no_write_when_full : assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i) wr.valid |-> !full);

endmodule

// File: vita_timer.sv
// VITA time counter, 64 bits, settable over the settings bus
`timescale 1ns/10ps
`include "u2_rx_config.svh"

module vita_timer (
   input  logic                  dsp_clk,
   input  logic                  rst_n_i,
   input  logic                  set_stb_i,
   input  u2_rx_pkg::set_addr_t  set_addr_i,
   input  u2_rx_pkg::set_data_t  set_data_i,
   output u2_rx_pkg::vita_time_t vita_time_o
);
   import u2_rx_pkg::*;

   localparam set_addr_t ADDR_HI = set_addr_t'(`U2_SR_TIME64);
   localparam set_addr_t ADDR_LO = set_addr_t'(`U2_SR_TIME64 + 1);

   set_data_t  time_hi;
   vita_time_t count;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         time_hi <= '0;
         count   <= '0;
      end else begin
         // High word waits here for the low-word write
         if (set_stb_i && set_addr_i == ADDR_HI) begin
            time_hi <= set_data_i;
         end
         if (set_stb_i && set_addr_i == ADDR_LO) begin
            count <= {time_hi, set_data_i};
         end else begin
            count <= count + 1'b1;
         end
      end
   end

   assign vita_time_o = count;

endmodule

// File: rx_stream_if.sv
// Frame stream with valid/ready handshake
// A word moves on a dsp_clk edge where valid and ready are both high
`timescale 1ns/10ps

interface rx_stream_if;
   import u2_rx_pkg::*;

   frame_word_t word;
   logic        valid;
   logic        ready;

   modport src (
      output word,
      output valid,
      input  ready
   );

   modport snk (
      input  word,
      input  valid,
      output ready
   );

endinterface

// File: u2_rx_pkg.sv
// Shared types of the dual receive path
// Settings bus, time, samples and frame words

package u2_rx_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   typedef logic [63:0] vita_time_t;

   // adc_a in the upper half, adc_b in the lower, both sign-extended
   typedef logic [31:0] sample_t;

   // One word of a channel frame
   typedef struct packed {
      logic        eop;
      logic        sop;
      logic [31:0] data;
   } frame_word_t;

   // Receive channel number
   typedef logic chan_id_t;

endpackage

// File: u2_rx_config.svh
// Receive path configuration
// Widths, FIFO depth and settings-bus register map

`ifndef U2_RX_CONFIG_SVH
`define U2_RX_CONFIG_SVH

// ADC sample width
`define U2_RX_ADC_W     14

// Channel FIFO, 2**5 = 32 frame words
`define U2_RX_FIFO_AW   5
`define U2_RX_MAX_SPF   15

// Settings bus bases
`define U2_SR_TIME64    192
`define U2_SR_RX_CTRL0  176
`define U2_SR_RX_CTRL1  32

`endif
